//--- rtl/lsq_cfg_pkg.sv
// LSQ configuration
// Queue depths, datapath widths and the pointer sizes derived from them

package lsq_cfg_pkg;

	localparam int xlen      = 64;  // Data and address width
	localparam int prf_tag_w = 6;   // Physical register tag
	localparam int rob_idx_w = 5;

	localparam int lq_depth = 8;
	localparam int sq_depth = 8;

	// Slot indexes
	localparam int lq_ptr_w = $clog2(lq_depth);
	localparam int sq_ptr_w = $clog2(sq_depth);

	// Store pointer plus wrap bit, used as the load ordering mark
	localparam int sq_mark_w = sq_ptr_w + 1;

endpackage

//--- rtl/lsq_types_pkg.sv
// LSQ types
// Opcode values accepted from rename, the decoded instruction class
// and the memory port states

package lsq_types_pkg;

	localparam int opcode_w = 6;

	localparam logic [opcode_w-1:0] op_ldq = 6'h29;  // Quadword load
	localparam logic [opcode_w-1:0] op_stq = 6'h2D;  // Quadword store

	// Decoded class of a dispatched instruction
	typedef enum logic [1:0] {
		class_none,
		class_load,
		class_store
	} mem_class_e;

	// Memory port, one load outstanding at most
	typedef enum logic {
		port_idle,
		port_wait_load
	} port_state_e;

endpackage

//--- rtl/lsq_dispatch.sv
`timescale 1ns/1ps
// LSQ dispatch
// Decodes the opcode from rename and pushes the instruction into the load
// or store queue, holding rename off when that queue is full or a flush runs

module lsq_dispatch (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               disp_valid,
	input  logic [lsq_types_pkg::opcode_w-1:0] disp_opcode,
	input  logic                               flush,
	input  logic                               lq_full,
	input  logic                               sq_full,
	output logic                               disp_ready,
	output logic                               lq_push,
	output logic                               sq_push
);
	lsq_types_pkg::mem_class_e op_class;
	logic flush_q;      // Flush seen last cycle
	logic target_full;
	logic accept;

	always_comb begin
		case (disp_opcode)
			lsq_types_pkg::op_ldq: op_class = lsq_types_pkg::class_load;
			lsq_types_pkg::op_stq: op_class = lsq_types_pkg::class_store;
			default:               op_class = lsq_types_pkg::class_none;
		endcase
	end

	// Only the queue this opcode goes to can stall it
	assign target_full = (op_class == lsq_types_pkg::class_load && lq_full) ||
		(op_class == lsq_types_pkg::class_store && sq_full);

	assign disp_ready = !flush && !flush_q && !target_full;
	assign accept     = disp_valid && disp_ready;
	assign lq_push    = accept && (op_class == lsq_types_pkg::class_load);
	assign sq_push    = accept && (op_class == lsq_types_pkg::class_store);  // Other opcodes drop

	always_ff @(posedge clock) begin
		if (reset) begin
			flush_q <= 1'b0;
		end else begin
			flush_q <= flush;
		end
	end

endmodule

//--- rtl/load_queue.sv
`timescale 1ns/1ps
// Load queue
// Circular buffer of loads that wait for their base operand and for all
// older stores to be written. The head goes to memory and its response
// goes straight to the result bus

module load_queue (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                lq_push,
	input  logic                                flush,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_base,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_base_tag,
	input  logic                                disp_base_ready,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_offset,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   disp_rob_idx,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_dest_tag,
	input  logic                                cdb_valid,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   cdb_tag,
	input  logic [lsq_cfg_pkg::xlen-1:0]        cdb_data,
	input  logic [lsq_cfg_pkg::sq_mark_w-1:0]   sq_tail_mark,
	input  logic [lsq_cfg_pkg::sq_mark_w-1:0]   sq_head_mark,
	input  logic                                ld_grant,
	input  logic                                ld_resp_valid,
	input  logic [lsq_cfg_pkg::xlen-1:0]        ld_resp_data,
	input  logic                                res_grant_ld,
	output logic                                lq_full,
	output logic                                ld_issue_valid,
	output logic [lsq_cfg_pkg::xlen-1:0]        ld_issue_addr,
	output logic                                res_req_ld,
	output logic [lsq_cfg_pkg::prf_tag_w-1:0]   res_ld_tag,
	output logic [lsq_cfg_pkg::xlen-1:0]        res_ld_data,
	output logic [lsq_cfg_pkg::rob_idx_w-1:0]   res_ld_rob_idx
);
	typedef enum logic [1:0] {ld_wait, ld_issued, ld_done} ld_state_e;

	// Entry fields
	logic [lsq_cfg_pkg::xlen-1:0]      base_q     [lsq_cfg_pkg::lq_depth];
	logic [lsq_cfg_pkg::prf_tag_w-1:0] base_tag_q [lsq_cfg_pkg::lq_depth];
	logic [lsq_cfg_pkg::lq_depth-1:0]  base_rdy_q;
	logic [lsq_cfg_pkg::xlen-1:0]      offset_q   [lsq_cfg_pkg::lq_depth];
	logic [lsq_cfg_pkg::sq_mark_w-1:0] mark_q     [lsq_cfg_pkg::lq_depth];  // Store tail at dispatch
	logic [lsq_cfg_pkg::rob_idx_w-1:0] rob_q      [lsq_cfg_pkg::lq_depth];
	logic [lsq_cfg_pkg::prf_tag_w-1:0] dest_q     [lsq_cfg_pkg::lq_depth];
	ld_state_e                         state_q    [lsq_cfg_pkg::lq_depth];

	logic [lsq_cfg_pkg::lq_ptr_w:0]   head, tail, head_nxt;
	logic [lsq_cfg_pkg::lq_ptr_w-1:0] head_idx, tail_idx;
	logic empty;
	logic squash;     // Next response belongs to a flushed load
	logic resp_hit;
	logic base_wake;

	assign head_idx = head[lsq_cfg_pkg::lq_ptr_w-1:0];
	assign tail_idx = tail[lsq_cfg_pkg::lq_ptr_w-1:0];
	assign empty    = (head == tail);
	assign lq_full  = (head_idx == tail_idx) &&
		(head[lsq_cfg_pkg::lq_ptr_w] != tail[lsq_cfg_pkg::lq_ptr_w]);
	assign head_nxt = res_grant_ld ? head + 1'b1 : head;

	assign resp_hit  = ld_resp_valid && !squash;
	assign base_wake = !disp_base_ready && cdb_valid && (cdb_tag == disp_base_tag);

	////////////////////
	// Head issue and result
	////////////////////

	// Older stores are written once the store head reaches the mark
	assign ld_issue_valid = !empty && (state_q[head_idx] == ld_wait) &&
		base_rdy_q[head_idx] && (mark_q[head_idx] == sq_head_mark);
	assign ld_issue_addr  = base_q[head_idx] + offset_q[head_idx];

	assign res_req_ld     = !empty && resp_hit;
	assign res_ld_tag     = dest_q[head_idx];
	assign res_ld_rob_idx = rob_q[head_idx];
	assign res_ld_data    = ld_resp_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			head   <= '0;
			tail   <= '0;
			squash <= 1'b0;
		end else begin
			head <= head_nxt;
			if (flush) begin
				tail <= head_nxt;
			end else if (lq_push) begin
				tail <= tail + 1'b1;
			end
			if (flush && (ld_grant ||
				(!empty && state_q[head_idx] == ld_issued && !ld_resp_valid))) begin
				squash <= 1'b1;
			end else if (ld_resp_valid) begin
				squash <= 1'b0;
			end
		end
	end

	////////////////////
	// Entry writes
	////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < lsq_cfg_pkg::lq_depth; i++) begin
			if (cdb_valid && !base_rdy_q[i] && (base_tag_q[i] == cdb_tag)) begin
				base_q[i]     <= cdb_data;   // Wake-up
				base_rdy_q[i] <= 1'b1;
			end
		end
		if (ld_grant) begin
			state_q[head_idx] <= ld_issued;
		end
		if (resp_hit) begin
			state_q[head_idx] <= ld_done;
		end
		// New entry overrides anything aimed at the stale slot
		if (lq_push) begin
			base_q[tail_idx]     <= base_wake ? cdb_data : disp_base;
			base_tag_q[tail_idx] <= disp_base_tag;
			base_rdy_q[tail_idx] <= disp_base_ready || base_wake;
			offset_q[tail_idx]   <= disp_offset;
			mark_q[tail_idx]     <= sq_tail_mark;
			rob_q[tail_idx]      <= disp_rob_idx;
			dest_q[tail_idx]     <= disp_dest_tag;
			state_q[tail_idx]    <= ld_wait;
		end
	end

endmodule

//--- rtl/store_queue.sv
`timescale 1ns/1ps
// Store queue
// Circular buffer of stores with head, report, commit and tail pointers.
// Stores report on the result bus once their operands are in, then are
// committed by retire and written to memory from the head in order

module store_queue (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                sq_push,
	input  logic                                flush,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_base,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_base_tag,
	input  logic                                disp_base_ready,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_offset,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_data,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_data_tag,
	input  logic                                disp_data_ready,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   disp_rob_idx,
	input  logic                                cdb_valid,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   cdb_tag,
	input  logic [lsq_cfg_pkg::xlen-1:0]        cdb_data,
	input  logic                                retire_valid,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   retire_rob_idx,
	input  logic                                st_grant,
	input  logic                                res_grant_st,
	output logic                                sq_full,
	output logic [lsq_cfg_pkg::sq_mark_w-1:0]   sq_tail_mark,
	output logic [lsq_cfg_pkg::sq_mark_w-1:0]   sq_head_mark,
	output logic                                st_issue_valid,
	output logic [lsq_cfg_pkg::xlen-1:0]        st_issue_addr,
	output logic [lsq_cfg_pkg::xlen-1:0]        st_issue_data,
	output logic                                res_req_st,
	output logic [lsq_cfg_pkg::rob_idx_w-1:0]   res_st_rob_idx
);
	logic [lsq_cfg_pkg::xlen-1:0]      base_q     [lsq_cfg_pkg::sq_depth];
	logic [lsq_cfg_pkg::prf_tag_w-1:0] base_tag_q [lsq_cfg_pkg::sq_depth];
	logic [lsq_cfg_pkg::xlen-1:0]      offset_q   [lsq_cfg_pkg::sq_depth];
	logic [lsq_cfg_pkg::xlen-1:0]      data_q     [lsq_cfg_pkg::sq_depth];
	logic [lsq_cfg_pkg::prf_tag_w-1:0] data_tag_q [lsq_cfg_pkg::sq_depth];
	logic [lsq_cfg_pkg::rob_idx_w-1:0] rob_q      [lsq_cfg_pkg::sq_depth];
	logic [lsq_cfg_pkg::sq_depth-1:0]  base_rdy_q, data_rdy_q;

	// Pointers carry a wrap bit
	logic [lsq_cfg_pkg::sq_mark_w-1:0] head, rpt, cmt, tail, cmt_nxt;
	logic [lsq_cfg_pkg::sq_ptr_w-1:0]  head_idx, rpt_idx, cmt_idx, tail_idx;
	logic commit;
	logic base_wake, data_wake;

	assign head_idx = head[lsq_cfg_pkg::sq_ptr_w-1:0];
	assign rpt_idx  = rpt[lsq_cfg_pkg::sq_ptr_w-1:0];
	assign cmt_idx  = cmt[lsq_cfg_pkg::sq_ptr_w-1:0];
	assign tail_idx = tail[lsq_cfg_pkg::sq_ptr_w-1:0];

	assign sq_full = (head_idx == tail_idx) &&
		(head[lsq_cfg_pkg::sq_ptr_w] != tail[lsq_cfg_pkg::sq_ptr_w]);
	assign sq_tail_mark = tail;
	assign sq_head_mark = head;

	// Completion report, in queue order
	assign res_req_st     = (rpt != tail) && base_rdy_q[rpt_idx] && data_rdy_q[rpt_idx];
	assign res_st_rob_idx = rob_q[rpt_idx];

	// Oldest reported store retires
	assign commit  = retire_valid && (cmt != rpt) && (rob_q[cmt_idx] == retire_rob_idx);
	assign cmt_nxt = commit ? cmt + 1'b1 : cmt;

	assign st_issue_valid = (head != cmt);
	assign st_issue_addr  = base_q[head_idx] + offset_q[head_idx];
	assign st_issue_data  = data_q[head_idx];

	assign base_wake = !disp_base_ready && cdb_valid && (cdb_tag == disp_base_tag);
	assign data_wake = !disp_data_ready && cdb_valid && (cdb_tag == disp_data_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			rpt  <= '0;
			cmt  <= '0;
			tail <= '0;
		end else begin
			cmt <= cmt_nxt;
			if (st_grant) begin
				head <= head + 1'b1;   // Freed once memory takes it
			end
			if (flush) begin
				rpt  <= cmt_nxt;      // Uncommitted stores go away
				tail <= cmt_nxt;
			end else begin
				if (res_grant_st) begin
					rpt <= rpt + 1'b1;
				end
				if (sq_push) begin
					tail <= tail + 1'b1;
				end
			end
		end
	end

	////////////////////
	// Entry writes
	////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < lsq_cfg_pkg::sq_depth; i++) begin
			if (cdb_valid && !base_rdy_q[i] && (base_tag_q[i] == cdb_tag)) begin
				base_q[i]     <= cdb_data;
				base_rdy_q[i] <= 1'b1;
			end
			if (cdb_valid && !data_rdy_q[i] && (data_tag_q[i] == cdb_tag)) begin
				data_q[i]     <= cdb_data;
				data_rdy_q[i] <= 1'b1;
			end
		end
		if (sq_push) begin
			base_q[tail_idx]     <= base_wake ? cdb_data : disp_base;
			base_tag_q[tail_idx] <= disp_base_tag;
			base_rdy_q[tail_idx] <= disp_base_ready || base_wake;
			offset_q[tail_idx]   <= disp_offset;
			data_q[tail_idx]     <= data_wake ? cdb_data : disp_data;
			data_tag_q[tail_idx] <= disp_data_tag;
			data_rdy_q[tail_idx] <= disp_data_ready || data_wake;
			rob_q[tail_idx]      <= disp_rob_idx;
		end
	end

endmodule

//--- rtl/lsq_arbiter.sv
`timescale 1ns/1ps
// LSQ arbiter
// Shares the memory port between the committed store and the head load,
// keeps track of the one outstanding load, and drives the result bus

module lsq_arbiter (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                flush,
	input  logic                                ld_issue_valid,
	input  logic [lsq_cfg_pkg::xlen-1:0]        ld_issue_addr,
	input  logic                                st_issue_valid,
	input  logic [lsq_cfg_pkg::xlen-1:0]        st_issue_addr,
	input  logic [lsq_cfg_pkg::xlen-1:0]        st_issue_data,
	input  logic                                mem_req_ready,
	input  logic                                mem_resp_valid,
	input  logic [lsq_cfg_pkg::xlen-1:0]        mem_resp_data,
	input  logic                                res_req_ld,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   res_ld_tag,
	input  logic [lsq_cfg_pkg::xlen-1:0]        res_ld_data,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   res_ld_rob_idx,
	input  logic                                res_req_st,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   res_st_rob_idx,
	output logic                                ld_grant,
	output logic                                st_grant,
	output logic                                mem_req_valid,
	output logic                                mem_req_write,
	output logic [lsq_cfg_pkg::xlen-1:0]        mem_req_addr,
	output logic [lsq_cfg_pkg::xlen-1:0]        mem_req_wdata,
	output logic                                ld_resp_valid,
	output logic [lsq_cfg_pkg::xlen-1:0]        ld_resp_data,
	output logic                                res_grant_ld,
	output logic                                res_grant_st,
	output logic                                result_valid,
	output logic [lsq_cfg_pkg::prf_tag_w-1:0]   result_tag,
	output logic [lsq_cfg_pkg::xlen-1:0]        result_data,
	output logic [lsq_cfg_pkg::rob_idx_w-1:0]   result_rob_idx
);
	lsq_types_pkg::port_state_e state;
	logic st_sel, ld_sel;

	////////////////////
	// Memory port
	////////////////////

	assign st_sel = (state == lsq_types_pkg::port_idle) && st_issue_valid;  // Store first
	assign ld_sel = (state == lsq_types_pkg::port_idle) && !st_issue_valid && ld_issue_valid;

	assign mem_req_valid = st_sel || ld_sel;
	assign mem_req_write = st_sel;
	assign mem_req_addr  = st_sel ? st_issue_addr : ld_issue_addr;
	assign mem_req_wdata = st_issue_data;
	assign st_grant      = st_sel && mem_req_ready;
	assign ld_grant      = ld_sel && mem_req_ready;

	assign ld_resp_valid = (state == lsq_types_pkg::port_wait_load) && mem_resp_valid;
	assign ld_resp_data  = mem_resp_data;

	// Loads win the result bus, a store report waits a cycle
	assign res_grant_ld = res_req_ld;
	assign res_grant_st = res_req_st && !res_req_ld;

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= lsq_types_pkg::port_idle;
			result_valid <= 1'b0;
		end else begin
			if (ld_grant) begin
				state <= lsq_types_pkg::port_wait_load;
			end else if (mem_resp_valid) begin
				state <= lsq_types_pkg::port_idle;
			end
			result_valid <= !flush && (res_req_ld || res_req_st);  // Flushed work never reports
		end
	end

	// Store reports carry only the rob index
	always_ff @(posedge clock) begin
		result_tag     <= res_req_ld ? res_ld_tag : '0;
		result_data    <= res_req_ld ? res_ld_data : '0;
		result_rob_idx <= res_req_ld ? res_ld_rob_idx : res_st_rob_idx;
	end

endmodule

//--- rtl/lsq_top.sv
`timescale 1ns/1ps
// Load/store queue top
// Dispatch steering, load queue, store queue and the memory and
// result bus arbiter for one thread

module lsq_top (
	input  logic                                clock,
	input  logic                                reset,
	// Dispatch from rename
	input  logic                                disp_valid,
	input  logic [lsq_types_pkg::opcode_w-1:0]  disp_opcode,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_base,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_base_tag,
	input  logic                                disp_base_ready,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_offset,
	input  logic [lsq_cfg_pkg::xlen-1:0]        disp_data,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_data_tag,
	input  logic                                disp_data_ready,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   disp_rob_idx,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   disp_dest_tag,
	output logic                                disp_ready,
	// CDB
	input  logic                                cdb_valid,
	input  logic [lsq_cfg_pkg::prf_tag_w-1:0]   cdb_tag,
	input  logic [lsq_cfg_pkg::xlen-1:0]        cdb_data,
	// Retire and mispredict
	input  logic                                retire_valid,
	input  logic [lsq_cfg_pkg::rob_idx_w-1:0]   retire_rob_idx,
	input  logic                                flush,
	// Memory
	output logic                                mem_req_valid,
	output logic                                mem_req_write,
	output logic [lsq_cfg_pkg::xlen-1:0]        mem_req_addr,
	output logic [lsq_cfg_pkg::xlen-1:0]        mem_req_wdata,
	input  logic                                mem_req_ready,
	input  logic                                mem_resp_valid,
	input  logic [lsq_cfg_pkg::xlen-1:0]        mem_resp_data,
	// Result bus
	output logic                                result_valid,
	output logic [lsq_cfg_pkg::prf_tag_w-1:0]   result_tag,
	output logic [lsq_cfg_pkg::xlen-1:0]        result_data,
	output logic [lsq_cfg_pkg::rob_idx_w-1:0]   result_rob_idx
);
	logic                              lq_push, sq_push, lq_full, sq_full;
	logic [lsq_cfg_pkg::sq_mark_w-1:0] sq_tail_mark, sq_head_mark;  // Load ordering marks

	logic                              ld_issue_valid, st_issue_valid;
	logic [lsq_cfg_pkg::xlen-1:0]      ld_issue_addr, st_issue_addr, st_issue_data;
	logic                              ld_grant, st_grant;
	logic                              ld_resp_valid;
	logic [lsq_cfg_pkg::xlen-1:0]      ld_resp_data;

	logic                              res_req_ld, res_grant_ld, res_req_st, res_grant_st;
	logic [lsq_cfg_pkg::prf_tag_w-1:0] res_ld_tag;
	logic [lsq_cfg_pkg::xlen-1:0]      res_ld_data;
	logic [lsq_cfg_pkg::rob_idx_w-1:0] res_ld_rob_idx, res_st_rob_idx;

	lsq_dispatch u_dispatch (.*);

	load_queue u_load_queue (.*);

	store_queue u_store_queue (.*);

	lsq_arbiter u_arbiter (.*);

endmodule

//--- tests/lsq_tb.sv
`timescale 1ns/1ps
// LSQ testbench
// Directed tests for the load/store queue with a small memory model,
// a result bus monitor and a watchdog

module lsq_tb;

	localparam int clk_period   = 8;
	localparam int reset_cycles = 10;
	// Cycle budgets of reset, forwarding, wake-up, back-pressure, flush and random tests
	localparam int budget_cycles = reset_cycles + 20 + 60 + 60 + 150 + 150 + 600;

	logic        clock, reset;
	logic        disp_valid, disp_base_ready, disp_data_ready, disp_ready;
	logic [5:0]  disp_opcode, disp_base_tag, disp_data_tag, disp_dest_tag;
	logic [63:0] disp_base, disp_offset, disp_data;
	logic [4:0]  disp_rob_idx, retire_rob_idx, result_rob_idx;
	logic        cdb_valid, retire_valid, flush;
	logic [5:0]  cdb_tag, result_tag;
	logic [63:0] cdb_data, mem_req_addr, mem_req_wdata, mem_resp_data, result_data;
	logic        mem_req_valid, mem_req_write, mem_req_ready, mem_resp_valid, result_valid;

	int errors, checks;
	int ready_mode;                 // 0 ready, 1 held low, 2 random

	bit [63:0]   mem [bit [63:0]];  // Memory model contents
	logic        log_write [$];     // Every transfer on the memory port
	logic [63:0] log_addr [$];
	logic [63:0] log_data [$];
	logic [5:0]  res_tag_q [$];     // Observed result bus traffic
	logic [63:0] res_data_q [$];
	logic [4:0]  res_rob_q [$];

	lsq_top u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	////////////////////
	// Memory model
	////////////////////

	function automatic logic [63:0] fill(input logic [63:0] a);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
	endfunction

	function automatic logic [63:0] mem_read(input logic [63:0] a);
		if (mem.exists(a))
			return mem[a];
		return fill(a);
	endfunction

	initial begin
		int          resp_timer;
		int          mode;
		logic [63:0] resp_buf;
		resp_timer = 0;
		resp_buf   = '0;
		forever begin
			@(posedge clock);
			mode = ready_mode;
			if (resp_timer > 0)
				resp_timer--;
			if (!reset && mem_req_valid === 1'b1 && mem_req_ready) begin
				log_write.push_back(mem_req_write);
				log_addr.push_back(mem_req_addr);
				if (mem_req_write) begin
					mem[mem_req_addr] = mem_req_wdata;   // Writes land on transfer
					log_data.push_back(mem_req_wdata);
				end else begin
					resp_buf   = mem_read(mem_req_addr);
					resp_timer = 2;                      // Answer two cycles later
					log_data.push_back(resp_buf);
				end
			end
			#1;
			mem_resp_valid = (resp_timer == 1);
			mem_resp_data  = resp_buf;
			mem_req_ready  = (mode == 0) || (mode == 2 && ($urandom % 2) == 1);
		end
	end

	// Result bus monitor
	initial begin
		forever begin
			@(posedge clock);
			if (result_valid === 1'b1) begin
				res_tag_q.push_back(result_tag);
				res_data_q.push_back(result_data);
				res_rob_q.push_back(result_rob_idx);
			end
		end
	end

	// Watchdog
	initial begin
		#(budget_cycles * clk_period * 2);
		$display("Watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	function automatic logic [5:0] opcode_of(input lsq_types_pkg::mem_class_e c);
		case (c)
			lsq_types_pkg::class_load:  return lsq_types_pkg::op_ldq;
			lsq_types_pkg::class_store: return lsq_types_pkg::op_stq;
			default:                    return 6'h00;
		endcase
	endfunction

	// Presents one instruction and holds it until rename sees ready
	task automatic dispatch(input lsq_types_pkg::mem_class_e c, input logic [63:0] base,
			input logic [5:0] base_tag, input logic base_ready, input logic [63:0] offset,
			input logic [63:0] data, input logic [4:0] rob, input logic [5:0] dest);
		int n;
		n = 0;
		@(posedge clock);
		#1;
		disp_valid      = 1'b1;
		disp_opcode     = opcode_of(c);
		disp_base       = base;
		disp_base_tag   = base_tag;
		disp_base_ready = base_ready;
		disp_offset     = offset;
		disp_data       = data;
		disp_rob_idx    = rob;
		disp_dest_tag   = dest;
		@(posedge clock);
		while (disp_ready !== 1'b1 && n < 200) begin
			@(posedge clock);
			n++;
		end
		if (disp_ready !== 1'b1)
			report_error("dispatch was never accepted");
		#1 disp_valid = 1'b0;
	endtask

	task automatic retire(input logic [4:0] rob);
		@(posedge clock);
		#1;
		retire_valid   = 1'b1;
		retire_rob_idx = rob;
		@(posedge clock);
		#1 retire_valid = 1'b0;
	endtask

	task automatic cdb_broadcast(input logic [5:0] tag, input logic [63:0] data);
		@(posedge clock);
		#1;
		cdb_valid = 1'b1;
		cdb_tag   = tag;
		cdb_data  = data;
		@(posedge clock);
		#1 cdb_valid = 1'b0;
	endtask

	task automatic pulse_flush();
		@(posedge clock);
		#1 flush = 1'b1;
		@(posedge clock);
		#1 flush = 1'b0;
	endtask

	// Pops the next observed result and compares all three fields
	task automatic expect_result(input logic [5:0] tag, input logic [63:0] data,
			input logic [4:0] rob);
		int n;
		n = 0;
		while (res_data_q.size() == 0 && n < 100) begin
			@(negedge clock);
			n++;
		end
		if (res_data_q.size() == 0) begin
			report_error("expected result never appeared on the result bus");
		end else begin
			check("result_tag", res_tag_q.pop_front(), tag);
			check("result_data", res_data_q.pop_front(), data);
			check("result_rob_idx", res_rob_q.pop_front(), rob);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (res_data_q.size() != 0) begin
			report_error("extra results appeared on the result bus");
			res_tag_q.delete();
			res_data_q.delete();
			res_rob_q.delete();
		end
		$display("%-16s %s", name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic test_reset();
		int err0;
		err0 = errors;
		@(negedge clock);
		check("disp_ready", disp_ready, 1'b1);
		check("mem_req_valid", mem_req_valid, 1'b0);
		check("result_valid", result_valid, 1'b0);
		finish_test("reset", err0);
	endtask

	task automatic test_store_load();
		int err0, base;
		err0 = errors;
		base = log_addr.size();
		dispatch(lsq_types_pkg::class_store, 64'h1000, 6'd0, 1'b1, 64'h28,
			64'hdead_beef_0123_4567, 5'd1, 6'd0);
		dispatch(lsq_types_pkg::class_load, 64'h1020, 6'd0, 1'b1, 64'h8, '0, 5'd2, 6'd5);
		expect_result(6'd0, 64'd0, 5'd1);   // Store report
		retire(5'd1);
		expect_result(6'd5, 64'hdead_beef_0123_4567, 5'd2);
		check("memory at 0x1028", mem_read(64'h1028), 64'hdead_beef_0123_4567);
		check("memory transfers", log_addr.size() - base, 2);
		if (log_addr.size() >= base + 2) begin
			check("first transfer mem_req_write", log_write[base], 1'b1);
			check("second transfer mem_req_write", log_write[base+1], 1'b0);
			check("load mem_req_addr", log_addr[base+1], 64'h1028);
		end
		finish_test("store then load", err0);
	endtask

	task automatic test_wakeup();
		int err0, base;
		err0 = errors;
		base = log_addr.size();
		dispatch(lsq_types_pkg::class_load, 64'h0, 6'd12, 1'b0, 64'h30, '0, 5'd3, 6'd7);
		repeat (6) @(negedge clock);
		check("mem_req_valid before wake-up", mem_req_valid, 1'b0);
		check("transfers before wake-up", log_addr.size() - base, 0);
		cdb_broadcast(6'd12, 64'h2_0000);
		expect_result(6'd7, mem_read(64'h2_0030), 5'd3);
		if (log_addr.size() == base + 1)
			check("mem_req_addr", log_addr[base], 64'h2_0030);
		else
			report_error("woken load did not make exactly one memory request");
		finish_test("cdb wake-up", err0);
	endtask

	task automatic test_backpressure();
		int err0;
		logic [63:0] exp_data [lsq_cfg_pkg::lq_depth];
		err0 = errors;
		ready_mode = 1;
		for (int i = 0; i < lsq_cfg_pkg::lq_depth; i++) begin
			exp_data[i] = mem_read(64'h4000 + i * 8);
			dispatch(lsq_types_pkg::class_load, 64'h4000, 6'd0, 1'b1, i * 8, '0,
				5'(8 + i), 6'(16 + i));
		end
		// One more load must be held off while the queue is full
		@(posedge clock);
		#1;
		disp_valid  = 1'b1;
		disp_offset = 64'h100;
		repeat (4) begin
			@(posedge clock);
			check("disp_ready with full load queue", disp_ready, 1'b0);
			check("mem_req_valid while stalled", mem_req_valid, 1'b1);
		end
		#1 disp_valid = 1'b0;
		ready_mode = 0;
		for (int i = 0; i < lsq_cfg_pkg::lq_depth; i++)
			expect_result(6'(16 + i), exp_data[i], 5'(8 + i));
		finish_test("back-pressure", err0);
	endtask

	task automatic test_flush();
		int err0, base;
		err0 = errors;
		base = log_addr.size();
		ready_mode = 1;   // Keep the committed store in the queue
		dispatch(lsq_types_pkg::class_store, 64'h8000, 6'd0, 1'b1, '0,
			64'h1111_2222_3333_4444, 5'd20, 6'd0);
		expect_result(6'd0, 64'd0, 5'd20);
		retire(5'd20);
		dispatch(lsq_types_pkg::class_store, 64'h9000, 6'd0, 1'b1, '0,
			64'h5555_6666_7777_8888, 5'd21, 6'd0);
		expect_result(6'd0, 64'd0, 5'd21);
		dispatch(lsq_types_pkg::class_load, 64'h8000, 6'd0, 1'b1, '0, '0, 5'd22, 6'd10);
		dispatch(lsq_types_pkg::class_load, 64'h9000, 6'd0, 1'b1, '0, '0, 5'd23, 6'd11);
		pulse_flush();
		ready_mode = 0;
		repeat (30) @(negedge clock);
		check("results after flush", res_data_q.size(), 0);
		check("writes after flush", log_addr.size() - base, 1);
		if (log_addr.size() == base + 1) begin
			check("committed store mem_req_addr", log_addr[base], 64'h8000);
			check("committed store mem_req_wdata", log_data[base], 64'h1111_2222_3333_4444);
		end
		check("flushed store in memory", mem.exists(64'h9000), 1'b0);
		dispatch(lsq_types_pkg::class_load, 64'h8000, 6'd0, 1'b1, '0, '0, 5'd24, 6'd12);
		expect_result(6'd12, 64'h1111_2222_3333_4444, 5'd24);
		finish_test("flush", err0);
	endtask

	task automatic test_random_stalls();
		int err0;
		logic [63:0] base, offset;
		logic [63:0] exp_data [20];
		err0 = errors;
		ready_mode = 2;
		for (int i = 0; i < 20; i++) begin
			base        = {$urandom, $urandom};
			offset      = $urandom % 64;
			exp_data[i] = mem_read(base + offset);
			dispatch(lsq_types_pkg::class_load, base, 6'd0, 1'b1, offset, '0,
				5'(i), 6'(32 + i));
		end
		for (int i = 0; i < 20; i++)
			expect_result(6'(32 + i), exp_data[i], 5'(i));
		ready_mode = 0;
		finish_test("random stalls", err0);
	endtask

	initial begin
		void'($urandom(32'hc07e));
		errors          = 0;
		checks          = 0;
		ready_mode      = 0;
		reset           = 1'b1;
		disp_valid      = 1'b0;
		disp_opcode     = '0;
		disp_base       = '0;
		disp_base_tag   = '0;
		disp_base_ready = 1'b0;
		disp_offset     = '0;
		disp_data       = '0;
		disp_data_tag   = '0;
		disp_data_ready = 1'b1;   // Store data is always ready here
		disp_rob_idx    = '0;
		disp_dest_tag   = '0;
		cdb_valid       = 1'b0;
		cdb_tag         = '0;
		cdb_data        = '0;
		retire_valid    = 1'b0;
		retire_rob_idx  = '0;
		flush           = 1'b0;
		mem_req_ready   = 1'b1;
		mem_resp_valid  = 1'b0;
		mem_resp_data   = '0;
		repeat (reset_cycles) @(posedge clock);
		#1 reset = 1'b0;

		test_reset();
		test_store_load();
		test_wakeup();
		test_backpressure();
		test_flush();
		test_random_stalls();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- verilog.f
rtl/lsq_cfg_pkg.sv
rtl/lsq_types_pkg.sv
rtl/lsq_dispatch.sv
rtl/load_queue.sv
rtl/store_queue.sv
rtl/lsq_arbiter.sv
rtl/lsq_top.sv
tests/lsq_tb.sv

//--- Bender.yml
package:
  name: lsq

sources:
  - rtl/lsq_cfg_pkg.sv
  - rtl/lsq_types_pkg.sv
  - rtl/lsq_dispatch.sv
  - rtl/load_queue.sv
  - rtl/store_queue.sv
  - rtl/lsq_arbiter.sv
  - rtl/lsq_top.sv
  - target: test
    files:
      - tests/lsq_tb.sv
